//--- run.sh
#!/bin/sh
# build and run the arbiter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module busArbiterTb \
  -Mdir obj_dir -o busArbiterSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/busArbiterSim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit $status
fi
exit 0

//--- sim.f
+incdir+verilog
verilog/arbiterPkg.sv
verilog/configDecode.sv
verilog/arbitrateExecute.sv
verilog/grantResult.sv
verilog/busArbiterTop.sv
tb/busArbiterTb.sv

//--- tb/arbiterCases.txt
# columns, all hex: cfgValid cfgWord request seed, then expected grant owner busy bus
# one line per clock, expected values are the result registered at that clock
0 00 00 11 00 0 0 0000
0 00 ff 01 01 0 1 4831
0 00 ff 02 02 1 1 0202
0 00 ff 03 04 2 1 d853
0 00 ff 04 08 3 1 0405
0 00 ff 05 10 4 1 68f5
0 00 ff 06 20 5 1 0605
0 00 ff 07 40 6 1 b117
0 00 ff 08 80 7 1 080c
0 00 ff 09 01 0 1 4039
0 00 92 0a 02 1 1 0a0a
0 00 92 0b 10 4 1 66fb
0 00 92 0c 80 7 1 0c08
0 00 92 0d 02 1 1 0d0d
0 00 21 0e 20 5 1 0e0d
0 00 21 0f 01 0 1 463f
0 00 21 10 20 5 1 1013
0 00 00 11 00 0 0 0000
0 00 48 12 40 6 1 a402
0 00 48 13 08 3 1 1312
1 0a 00 14 00 0 0 0000
1 16 00 15 00 0 0 0000
1 2c 00 16 00 0 0 0000
1 32 00 17 00 0 0 0000
1 48 00 18 00 0 0 0000
1 54 00 19 00 0 0 0000
1 6e 00 1a 00 0 0 0000
1 c0 00 1b 00 0 0 0000
0 00 ff 20 80 7 1 2024
0 00 7f 22 08 3 1 2223
0 00 7f 23 08 3 1 2322
0 00 77 24 20 5 1 2427
0 00 57 25 02 1 1 2525
1 22 00 26 00 0 0 0000
1 62 00 27 00 0 0 0000
0 00 7f 30 04 2 1 eb60
0 00 7f 31 08 3 1 3130
0 00 7f 32 40 6 1 8422
0 00 7f 33 04 2 1 e863
0 00 4b 34 08 3 1 3435
0 00 4b 35 40 6 1 8325
1 80 4b 36 08 3 1 3637
0 00 0b 37 01 0 1 7e07
0 00 0b 38 02 1 1 3838
0 00 00 39 00 0 0 0000

//--- tb/busArbiterTb.sv
`timescale 1ns/1ps

`include "arbiterMacros_macros.svh"

module busArbiterTb;

  // DUT ports
  logic clock;
  logic reset;
  logic cfgValid;
  arbiterPkg::cfgWord_t cfgWord;
  logic [`ARB_UNITS-1:0] request;
  arbiterPkg::unitData_t unitData;
  arbiterPkg::grantResult_t result;

  // one data key per unit, drawn from the LFSR before the first case
  logic [`ARB_DATA_WIDTH-1:0] unitKey [`ARB_UNITS];
  logic [31:0] lfsrState;

  busArbiterTop i_dut
  (
    .clock(clock),
    .reset(reset),
    .cfgValid(cfgValid),
    .cfgWord(cfgWord),
    .request(request),
    .unitData(unitData),
    .result(result)
  );

  // 100 ns period
  always #50 clock = ~clock;

  // reset low for 16 rising edges, released on a falling edge
  initial
  begin
    reset = 1'b0;
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
  end

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------

  // one Galois step, feedback into the top two bits
  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    logic [31:0] shifted;
    shifted = state >> 1;
    if (state[0])
      shifted = shifted ^ 32'hC000_0000;
    return shifted;
  endfunction

  // 16 bits per unit, first bit taken lands in the msb
  task automatic drawKeys();
    for (int u = 0; u < `ARB_UNITS; u++)
    begin
      unitKey[u] = '0;
      for (int b = 0; b < `ARB_DATA_WIDTH; b++)
      begin
        unitKey[u] = {unitKey[u][`ARB_DATA_WIDTH-2:0], lfsrState[0]};
        lfsrState = nextLfsr(lfsrState);
      end
    end
  endtask

  // unit word is its key xor the line seed in both bytes
  function automatic arbiterPkg::unitData_t spreadData(input logic [7:0] seed);
    arbiterPkg::unitData_t words;
    for (int u = 0; u < `ARB_UNITS; u++)
      words[u] = unitKey[u] ^ {seed, seed};
    return words;
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compareGrant(input logic [`ARB_UNITS-1:0] got,
                              input logic [`ARB_UNITS-1:0] expected, input int caseNo);
    if (got !== expected)
      failRun($sformatf("MISMATCH at %0t: case %0d grant %b, expected %b",
                        $time, caseNo, got, expected));
  endtask

  task automatic compareResult(input arbiterPkg::grantResult_t got,
                               input arbiterPkg::grantResult_t expected, input int caseNo);
    if (got !== expected)
      failRun($sformatf("MISMATCH at %0t: case %0d owner %0d busy %b bus %h, expected %0d %b %h",
                        $time, caseNo, got.owner, got.busy, got.data,
                        expected.owner, expected.busy, expected.data));
  endtask

  // ----------------------------------------------------------
  // stimulus and checks
  // ----------------------------------------------------------

  initial
  begin
    int fd;
    int tries;
    int waited;
    int caseNo;
    int fileLines;
    int got;
    string text;
    logic [31:0] col [8];
    arbiterPkg::grantResult_t expected;

    clock = 1'b0;
    cfgValid = 1'b0;
    cfgWord = '0;
    request = '0;
    unitData = '0;
    lfsrState = 32'hc92;
    drawKeys();

    fd = 0;
    tries = 0;
    while (fd == 0 && tries < 4)
    begin
      fd = $fopen("tb/arbiterCases.txt", "r");
      tries++;
      if (fd == 0)
        #1;
    end
    if (fd == 0)
      failRun("could not open tb/arbiterCases.txt for reading");

    // release is seen on a rising edge, where reset is stable
    waited = 0;
    while (reset !== 1'b1 && waited < 64)
    begin
      @(posedge clock);
      waited++;
    end
    if (reset !== 1'b1)
      failRun("reset was not released within 64 cycles");
    @(negedge clock);
    compareResult(result, '0, 0);

    caseNo = 0;
    fileLines = 0;
    while (!$feof(fd) && fileLines < 256)
    begin
      text = "";
      got = $fgets(text, fd);
      fileLines++;
      // 8'h23 is the note marker, blank lines are skipped too
      if (got > 0 && text.len() > 1 && text.getc(0) != 8'h23)
      begin
        got = $sscanf(text, "%h %h %h %h %h %h %h %h",
                      col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7]);
        if (got != 8)
          failRun($sformatf("case file line %0d does not hold eight columns", fileLines));
        caseNo++;
        cfgValid = col[0][0];
        cfgWord = col[1][7:0];
        request = col[2][`ARB_UNITS-1:0];
        unitData = spreadData(col[3][7:0]);
        expected.grant = col[4][`ARB_UNITS-1:0];
        expected.owner = col[5][`ARB_INDEX_WIDTH-1:0];
        expected.busy = col[6][0];
        expected.data = col[7][`ARB_DATA_WIDTH-1:0];
        // registered on the rising edge, read back on the next falling one
        @(negedge clock);
        compareGrant(result.grant, expected.grant, caseNo);
        compareResult(result, expected, caseNo);
      end
    end
    $fclose(fd);

    if (caseNo == 0)
      failRun("no cases were read from tb/arbiterCases.txt");
    else
    begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

//--- verilog/arbiterMacros_macros.svh
`ifndef ARBITER_MACROS_SVH
`define ARBITER_MACROS_SVH

// number of bus masters sharing the bus
`define ARB_UNITS 8

// bits to address one unit, also the width of one priority entry
`define ARB_INDEX_WIDTH 3

// width of each master's data word and of the bus
`define ARB_DATA_WIDTH 16

// kind flag of a configuration word
`define ARB_KIND_PRIO 1'b0
`define ARB_KIND_MODE 1'b1

// arbitration mode, round-robin or priority
`define ARB_MODE_ROUND 1'b0
`define ARB_MODE_PRIO 1'b1

`endif

//--- verilog/arbiterPkg.sv
`include "arbiterMacros_macros.svh"

package arbiterPkg;

  // ----------------------------------------------------------
  // configuration word, one byte read in two ways
  // ----------------------------------------------------------

  // kind 0: load one entry of the priority table
  typedef struct packed {
    logic kind;
    logic [`ARB_INDEX_WIDTH-1:0] unit;
    logic [`ARB_INDEX_WIDTH-1:0] prio;
    logic pad;
  } prioWrite_t;

  // kind 1: select round-robin or priority arbitration
  typedef struct packed {
    logic kind;
    logic roundOrPriority;
    logic [2*`ARB_INDEX_WIDTH-1:0] pad;
  } modeWrite_t;

  typedef union packed {
    prioWrite_t prioWrite;
    modeWrite_t modeWrite;
  } cfgWord_t;

  // decoded configuration handed from decode to execute
  typedef struct packed {
    logic roundOrPriority;
    logic [`ARB_UNITS-1:0][`ARB_INDEX_WIDTH-1:0] prio;
  } arbConfig_t;

  // registered arbitration result as seen on the bus side
  typedef struct packed {
    logic [`ARB_UNITS-1:0] grant;
    logic [`ARB_INDEX_WIDTH-1:0] owner;
    logic busy;
    logic [`ARB_DATA_WIDTH-1:0] data;
  } grantResult_t;

  // one data word per master
  typedef logic [`ARB_UNITS-1:0][`ARB_DATA_WIDTH-1:0] unitData_t;

endpackage

//--- verilog/arbitrateExecute.sv
`timescale 1ns/1ps

`include "arbiterMacros_macros.svh"

module arbitrateExecute
(
  input logic clock,
  input logic reset,
  input arbiterPkg::arbConfig_t arbCfg,
  input logic [`ARB_UNITS-1:0] request,
  input logic [`ARB_UNITS-1:0] grant,
  output logic [`ARB_UNITS-1:0] grantNext
);

  // ----------------------------------------------------------
  // local signals
  // ----------------------------------------------------------

  // priorities of requesting units, idle units forced to the top value
  logic [`ARB_INDEX_WIDTH-1:0] selectPrio [`ARB_UNITS];
  // lowest priority value among requesters
  logic [`ARB_INDEX_WIDTH-1:0] minPrio;
  // units whose table entry equals the minimum
  logic [`ARB_UNITS-1:0] isMin;
  // requests that take part in the scan for the current mode
  logic [`ARB_UNITS-1:0] candidates;

  // round-robin state
  logic [`ARB_INDEX_WIDTH-1:0] pointer;
  logic [`ARB_INDEX_WIDTH-1:0] grantIndex;
  logic [`ARB_INDEX_WIDTH-1:0] pointerAdvance;
  logic [`ARB_INDEX_WIDTH-1:0] scanStart;

  // scan order and running "already found" chain
  logic [`ARB_INDEX_WIDTH-1:0] scan [`ARB_UNITS];
  logic [`ARB_UNITS-2:0] found;

  // ----------------------------------------------------------
  // minimum priority filter
  // ----------------------------------------------------------

  always_comb
  begin
    for (int i = 0; i < `ARB_UNITS; i++)
    begin
      selectPrio[i] = request[i] ? arbCfg.prio[i] : '1;
    end
  end

  always_comb
  begin
    minPrio = selectPrio[0];
    for (int i = 1; i < `ARB_UNITS; i++)
    begin
      if (selectPrio[i] < minPrio)
        minPrio = selectPrio[i];
    end
  end

  always_comb
  begin
    for (int i = 0; i < `ARB_UNITS; i++)
    begin
      isMin[i] = (arbCfg.prio[i] == minPrio);
    end
  end

  // priority mode keeps only the minimum-valued requesters
  assign candidates = (arbCfg.roundOrPriority == `ARB_MODE_PRIO) ?
                      (isMin & request) : request;

  // ----------------------------------------------------------
  // round-robin pointer
  // ----------------------------------------------------------

  // index of the unit holding the registered grant
  always_comb
  begin
    grantIndex = '0;
    for (int i = 0; i < `ARB_UNITS; i++)
    begin
      if (grant[i])
        grantIndex = `ARB_INDEX_WIDTH'(i);
    end
  end

  // one past the last winner, wrapping at the unit count
  assign pointerAdvance = (int'(grantIndex) == `ARB_UNITS - 1) ? '0 : grantIndex + 1'b1;

  // a fresh grant moves the scan start this cycle, otherwise hold
  assign scanStart = (|grant) ? pointerAdvance : pointer;

  always_ff @(posedge clock)
  begin
    if (!reset)
      pointer <= '0;
    else
      pointer <= scanStart;
  end

  // ----------------------------------------------------------
  // scan and winner select
  // ----------------------------------------------------------

  always_comb
  begin
    int scanSum;
    for (int s = 0; s < `ARB_UNITS; s++)
    begin
      scanSum = int'(scanStart) + s;
      if (scanSum >= `ARB_UNITS)
        scanSum = scanSum - `ARB_UNITS;
      scan[s] = `ARB_INDEX_WIDTH'(scanSum);
    end
  end

  // found[t] set once any unit up to scan position t is a candidate
  always_comb
  begin
    found[0] = candidates[scan[0]];
    for (int t = 1; t < `ARB_UNITS - 1; t++)
    begin
      found[t] = found[t-1] | candidates[scan[t]];
    end
  end

  // first candidate in scan order wins
  always_comb
  begin
    grantNext = '0;
    grantNext[scan[0]] = candidates[scan[0]];
    for (int u = 1; u < `ARB_UNITS; u++)
    begin
      grantNext[scan[u]] = candidates[scan[u]] & ~found[u-1];
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------

  // never grant a unit that is not asking
  // and never leave the bus idle while someone asks
  grantWithinRequest: assert property (
    @(posedge clock) disable iff (!reset)
    ((grantNext & ~request) == '0) && ((|grantNext) == (|request))
  );

endmodule

//--- verilog/busArbiterTop.sv
`timescale 1ns/1ps

`include "arbiterMacros_macros.svh"

module busArbiterTop
(
  input logic clock,
  input logic reset,
  input logic cfgValid,
  input arbiterPkg::cfgWord_t cfgWord,
  input logic [`ARB_UNITS-1:0] request,
  input arbiterPkg::unitData_t unitData,
  output arbiterPkg::grantResult_t result
);

  // ----------------------------------------------------------
  // internal wires
  // ----------------------------------------------------------

  // decoded table and mode
  arbiterPkg::arbConfig_t arbCfg;
  // combinational winner for the next edge
  logic [`ARB_UNITS-1:0] grantNext;
  // registered grant looped back to the pointer
  logic [`ARB_UNITS-1:0] grant;

  // ----------------------------------------------------------
  // decode, execute, result
  // ----------------------------------------------------------

  configDecode i_configDecode
  (
    .clock(clock),
    .reset(reset),
    .cfgValid(cfgValid),
    .cfgWord(cfgWord),
    .arbCfg(arbCfg)
  );

  arbitrateExecute i_arbitrateExecute
  (
    .clock(clock),
    .reset(reset),
    .arbCfg(arbCfg),
    .request(request),
    .grant(grant),
    .grantNext(grantNext)
  );

  // one register stage, so requests show on the bus one cycle later
  grantResult i_grantResult
  (
    .clock(clock),
    .reset(reset),
    .grantNext(grantNext),
    .unitData(unitData),
    .result(result),
    .grant(grant)
  );

endmodule

//--- verilog/configDecode.sv
`timescale 1ns/1ps

`include "arbiterMacros_macros.svh"

module configDecode
(
  input logic clock,
  input logic reset,
  input logic cfgValid,
  input arbiterPkg::cfgWord_t cfgWord,
  output arbiterPkg::arbConfig_t arbCfg
);

  // ----------------------------------------------------------
  // registered configuration
  // ----------------------------------------------------------

  // mode bit plus one priority per unit
  arbiterPkg::arbConfig_t cfgReg;

  // fields pulled out of the two views of the word
  logic cfgKind;
  logic [`ARB_INDEX_WIDTH-1:0] writeUnit;
  logic [`ARB_INDEX_WIDTH-1:0] writePrio;
  logic writeMode;

  // kind flag sits in the same bit for both views
  assign cfgKind = cfgWord.prioWrite.kind;

  // priority view, target unit and new value
  assign writeUnit = cfgWord.prioWrite.unit;
  assign writePrio = cfgWord.prioWrite.prio;

  // mode view, 1 selects priority arbitration
  assign writeMode = cfgWord.modeWrite.roundOrPriority;

  // ----------------------------------------------------------
  // table and mode update
  // ----------------------------------------------------------

  always_ff @(posedge clock)
  begin
    if (!reset)
    begin
      // all priorities equal, plain round-robin after reset
      cfgReg.prio <= '0;
      cfgReg.roundOrPriority <= `ARB_MODE_ROUND;
    end
    else if (cfgValid)
    begin
      case (cfgKind)
        `ARB_KIND_PRIO:
        begin
          // one table entry per strobe
          cfgReg.prio[writeUnit] <= writePrio;
        end
        `ARB_KIND_MODE:
        begin
          // table left untouched on a mode write
          cfgReg.roundOrPriority <= writeMode;
        end
        default:
        begin
          cfgReg <= cfgReg;
        end
      endcase
    end
  end

  // new settings act on the arbitration right after the strobe edge
  assign arbCfg = cfgReg;

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------

  // a strobed word must be fully defined, else the table picks up X
  cfgWordKnown: assert property (
    @(posedge clock) disable iff (!reset)
    cfgValid |-> !$isunknown(cfgWord)
  );

endmodule

//--- verilog/grantResult.sv
`timescale 1ns/1ps

`include "arbiterMacros_macros.svh"

module grantResult
(
  input logic clock,
  input logic reset,
  input logic [`ARB_UNITS-1:0] grantNext,
  input arbiterPkg::unitData_t unitData,
  output arbiterPkg::grantResult_t result,
  output logic [`ARB_UNITS-1:0] grant
);

  // ----------------------------------------------------------
  // owner encode and data select
  // ----------------------------------------------------------

  // index of the winning unit, 0 when idle
  logic [`ARB_INDEX_WIDTH-1:0] ownerNext;
  // winner's data word, 0 when idle
  logic [`ARB_DATA_WIDTH-1:0] dataNext;

  // grantNext is one-hot or zero, so OR-ing the selected words is a mux
  always_comb
  begin
    ownerNext = '0;
    dataNext = '0;
    for (int i = 0; i < `ARB_UNITS; i++)
    begin
      if (grantNext[i])
      begin
        ownerNext = `ARB_INDEX_WIDTH'(i);
        dataNext = dataNext | unitData[i];
      end
    end
  end

  // ----------------------------------------------------------
  // result register
  // ----------------------------------------------------------

  always_ff @(posedge clock)
  begin
    if (!reset)
    begin
      result <= '0;
    end
    else
    begin
      result.grant <= grantNext;
      result.owner <= ownerNext;
      // bus is held whenever someone owns it
      result.busy <= |grantNext;
      result.data <= dataNext;
    end
  end

  // same flops fed back to the round-robin pointer
  assign grant = result.grant;

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------

  // at most one owner at a time on the shared bus
  grantOneHot: assert property (
    @(posedge clock) disable iff (!reset)
    $onehot0(result.grant)
  );

endmodule
